// File: design/arp_pkg.sv
`default_nettype none

package arp_pkg;

	////////////////////////////////////////////////////////////
	// Widths with a meaning

	typedef logic [47:0] mac_addr_t;
	typedef logic [31:0] ipv4_addr_t;
	typedef logic [31:0] eth_word_t;
	// Valid bytes in a stream word, 1 to 4
	typedef logic [2:0]  byte_count_t;
	typedef logic [7:0]  apb_addr_t;
	typedef logic [15:0] perf_count_t;

	////////////////////////////////////////////////////////////
	// Stream buses

	// Receive side, at the MAC and behind the header parser
	typedef struct packed {
		logic        start;
		logic        data_valid;
		byte_count_t bytes_valid;
		eth_word_t   data;
		logic        commit;
		logic        drop;
	} eth_rx_bus_t;

	// Reply body plus its destination, responder to framer
	typedef struct packed {
		logic        start;
		logic        data_valid;
		byte_count_t bytes_valid;
		eth_word_t   data;
		mac_addr_t   dst_mac;
		logic        commit;
		logic        drop;
	} eth_tx_l2_bus_t;

	// Protocol constants
	localparam logic [15:0] ETHERTYPE_ARP   = 16'h0806;
	localparam logic [15:0] ETHERTYPE_IPV4  = 16'h0800;
	localparam logic [15:0] ARP_OP_REQUEST  = 16'h0001;
	localparam logic [15:0] ARP_OP_REPLY    = 16'h0002;
	localparam logic [15:0] ARP_HW_ETHERNET = 16'h0001;
	localparam mac_addr_t   BROADCAST_MAC   = '1;

	// APB register map, byte addresses
	localparam apb_addr_t REG_MAC_HI  = 8'h00;
	localparam apb_addr_t REG_MAC_LO  = 8'h04;
	localparam apb_addr_t REG_IP      = 8'h08;
	localparam apb_addr_t REG_REPLIES = 8'h0C;
	localparam apb_addr_t REG_LOST    = 8'h10;

endpackage

`default_nettype wire

// File: design/eth_rx_header_parser.sv
`timescale 1ns/10ps
`default_nettype none

module eth_rx_header_parser import arp_pkg::*; (
	input  wire              clk,
	input  wire              rst,
	input  wire eth_rx_bus_t rx_bus,
	input  wire mac_addr_t   our_mac,
	output eth_rx_bus_t      l2_bus,
	output logic             headers_valid,
	output logic             ethertype_is_arp
);

	// Index 4 means the header is done and words are payload
	localparam logic [2:0] HDR_WORDS = 3'd4;

	logic [2:0]  hdr_idx;
	logic [2:0]  cur_idx;
	logic [15:0] dst_hi;
	mac_addr_t   dst_mac;
	logic        dst_ok;

	// A word arriving with start is word 0 of the new frame
	always_comb begin
		cur_idx = rx_bus.start ? 3'd0 : hdr_idx;
		// Full destination, valid while word 1 is on the bus
		dst_mac = {dst_hi, rx_bus.data};
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			hdr_idx           <= '0;
			dst_ok            <= 1'b0;
			headers_valid     <= 1'b0;
			ethertype_is_arp  <= 1'b0;
			l2_bus.start      <= 1'b0;
			l2_bus.data_valid <= 1'b0;
			l2_bus.commit     <= 1'b0;
			l2_bus.drop       <= 1'b0;
		end else begin
			// Frame markers go through with one cycle of delay
			l2_bus.start      <= rx_bus.start;
			l2_bus.commit     <= rx_bus.commit;
			l2_bus.drop       <= rx_bus.drop;
			l2_bus.data_valid <= 1'b0;
			headers_valid     <= 1'b0;

			if (rx_bus.start) begin
				hdr_idx <= '0;
				dst_ok  <= 1'b0;
			end

			if (rx_bus.data_valid) begin
				case (cur_idx)
					// Alignment pad, then dst[47:32]
					3'd0: dst_hi <= rx_bus.data[15:0];
					// dst[31:0], filter on our MAC or broadcast
					3'd1: begin
						dst_ok <= (dst_mac == our_mac) || (dst_mac == BROADCAST_MAC);
						if ((dst_mac != our_mac) && (dst_mac != BROADCAST_MAC))
							l2_bus.drop <= 1'b1;
					end
					// Source MAC is of no interest here
					3'd2: ;
					// src[15:0] plus ethertype
					3'd3: begin
						ethertype_is_arp <= rx_bus.data[15:0] == ETHERTYPE_ARP;
						headers_valid    <= dst_ok;
					end
					// Payload of frames that passed the filter
					default: begin
						l2_bus.data_valid  <= dst_ok;
						l2_bus.data        <= rx_bus.data;
						l2_bus.bytes_valid <= rx_bus.bytes_valid;
					end
				endcase

				if (cur_idx != HDR_WORDS)
					hdr_idx <= cur_idx + 3'd1;
			end
		end
	end

endmodule

`default_nettype wire

// File: design/arp_responder.sv
`timescale 1ns/10ps
`default_nettype none

module arp_responder import arp_pkg::*; (
	input  wire              clk,
	input  wire              rst,
	input  wire eth_rx_bus_t l2_bus,
	input  wire              headers_valid,
	input  wire              ethertype_is_arp,
	input  wire mac_addr_t   our_mac,
	input  wire ipv4_addr_t  our_ip,
	output eth_tx_l2_bus_t   reply_bus
);

	typedef enum logic [3:0] {
		ST_IDLE,
		ST_L2_HEADER,
		ST_BODY_0,
		ST_BODY_1,
		ST_BODY_2,
		ST_BODY_3,
		ST_BODY_4,
		ST_BODY_5,
		ST_BODY_6,
		ST_COMMIT
	} state_t;

	state_t     state;
	mac_addr_t  sender_mac;
	ipv4_addr_t sender_ip;
	ipv4_addr_t target_ip;
	logic       word_ok;
	logic       word_bad;
	logic       in_frame;

	// Every body word must carry all 4 bytes
	assign word_ok  = l2_bus.data_valid && (l2_bus.bytes_valid == 3'd4);
	assign word_bad = l2_bus.data_valid && (l2_bus.bytes_valid != 3'd4);
	// Waiting for header or body words
	assign in_frame = (state != ST_IDLE) && (state != ST_COMMIT);

	always_ff @(posedge clk) begin
		if (rst) begin
			state                <= ST_IDLE;
			reply_bus.start      <= 1'b0;
			reply_bus.data_valid <= 1'b0;
			reply_bus.commit     <= 1'b0;
			reply_bus.drop       <= 1'b0;
		end else begin
			reply_bus.start       <= l2_bus.start;
			reply_bus.drop        <= l2_bus.drop;
			reply_bus.data_valid  <= 1'b0;
			reply_bus.commit      <= 1'b0;
			reply_bus.bytes_valid <= 3'd4;

			case (state)
				ST_IDLE:
					if (l2_bus.start)
						state <= ST_L2_HEADER;

				// Only ARP goes on, other ethertypes are dropped
				ST_L2_HEADER:
					if (headers_valid) begin
						if (ethertype_is_arp) begin
							state <= ST_BODY_0;
						end else begin
							state          <= ST_IDLE;
							reply_bus.drop <= 1'b1;
						end
					end

				////////////////////////////////////////////////////////////
				// Body, one reply word per request word

				// HTYPE Ethernet, PTYPE IPv4, echoed unchanged
				ST_BODY_0:
					if (word_ok) begin
						if (l2_bus.data == {ARP_HW_ETHERNET, ETHERTYPE_IPV4}) begin
							state                <= ST_BODY_1;
							reply_bus.data_valid <= 1'b1;
							reply_bus.data       <= {ARP_HW_ETHERNET, ETHERTYPE_IPV4};
						end else begin
							state          <= ST_IDLE;
							reply_bus.drop <= 1'b1;
						end
					end

				// HLEN 6, PLEN 4, only requests get answered
				ST_BODY_1:
					if (word_ok) begin
						if (l2_bus.data == {16'h0604, ARP_OP_REQUEST}) begin
							state                <= ST_BODY_2;
							reply_bus.data_valid <= 1'b1;
							reply_bus.data       <= {16'h0604, ARP_OP_REPLY};
						end else begin
							// Replies and unknown opcodes end here
							state          <= ST_IDLE;
							reply_bus.drop <= 1'b1;
						end
					end

				// SHA upper, answered with our MAC upper
				ST_BODY_2:
					if (word_ok) begin
						state                <= ST_BODY_3;
						sender_mac[47:16]    <= l2_bus.data;
						reply_bus.data_valid <= 1'b1;
						reply_bus.data       <= our_mac[47:16];
					end

				// SHA lower plus SPA upper
				ST_BODY_3:
					if (word_ok) begin
						state                 <= ST_BODY_4;
						sender_mac[15:0]      <= l2_bus.data[31:16];
						sender_ip[31:16]      <= l2_bus.data[15:0];
						reply_bus.data_valid  <= 1'b1;
						reply_bus.data        <= {our_mac[15:0], our_ip[31:16]};
					end

				// SPA lower plus THA upper, sender MAC now complete
				ST_BODY_4:
					if (word_ok) begin
						state                <= ST_BODY_5;
						sender_ip[15:0]      <= l2_bus.data[31:16];
						reply_bus.data_valid <= 1'b1;
						reply_bus.data       <= {our_ip[15:0], sender_mac[47:32]};
						reply_bus.dst_mac    <= sender_mac;
					end

				// THA lower, not needed
				ST_BODY_5:
					if (word_ok) begin
						state                <= ST_BODY_6;
						reply_bus.data_valid <= 1'b1;
						reply_bus.data       <= sender_mac[31:0];
					end

				// TPA, checked once the frame is complete
				ST_BODY_6:
					if (word_ok) begin
						state                <= ST_COMMIT;
						target_ip            <= l2_bus.data;
						reply_bus.data_valid <= 1'b1;
						reply_bus.data       <= sender_ip;
					end

				// Trailing pad is ignored until the frame commits
				ST_COMMIT:
					if (target_ip != our_ip) begin
						state          <= ST_IDLE;
						reply_bus.drop <= 1'b1;
					end else if (l2_bus.commit) begin
						state            <= ST_IDLE;
						reply_bus.commit <= 1'b1;
					end

				default: state <= ST_IDLE;
			endcase

			// Short word or early end of frame
			if (in_frame && (word_bad || l2_bus.commit)) begin
				state          <= ST_IDLE;
				reply_bus.drop <= 1'b1;
			end

			// Aborted frame cancels whatever is in progress
			if (l2_bus.drop)
				state <= ST_IDLE;
		end
	end

endmodule

`default_nettype wire

// File: design/eth_tx_framer.sv
`timescale 1ns/10ps
`default_nettype none

module eth_tx_framer import arp_pkg::*; (
	input  wire                 clk,
	input  wire                 rst,
	input  wire eth_tx_l2_bus_t reply_bus,
	input  wire mac_addr_t      our_mac,
	input  wire                 tx_ready,
	output logic                tx_valid,
	output eth_word_t           tx_data,
	output logic                tx_last,
	output byte_count_t         tx_bytes_valid,
	output logic                reply_sent,
	output logic                reply_lost
);

	localparam int         BODY_WORDS = 7;
	// 4 header words plus 7 body words
	localparam logic [3:0] LAST_IDX   = 4'd10;

	eth_word_t  body_buf [BODY_WORDS];
	logic [2:0] wr_idx;
	mac_addr_t  dst_q;
	logic [3:0] tx_idx;
	logic [2:0] body_idx;
	logic       busy;
	// Reply started while a frame was on the wire
	logic       skip;
	logic       body_full;
	logic       wr_en;

	assign body_full      = wr_idx == 3'(BODY_WORDS);
	assign wr_en          = reply_bus.data_valid && !busy && !skip && !body_full;
	assign body_idx       = 3'(tx_idx - 4'd4);
	assign tx_valid       = busy;
	assign tx_last        = busy && (tx_idx == LAST_IDX);
	assign tx_bytes_valid = 3'd4;

	// Header in front, then the buffered body
	always_comb begin
		case (tx_idx)
			4'd0:    tx_data = {16'h0000, dst_q[47:32]};
			4'd1:    tx_data = dst_q[31:0];
			4'd2:    tx_data = our_mac[47:16];
			4'd3:    tx_data = {our_mac[15:0], ETHERTYPE_ARP};
			default: tx_data = body_buf[body_idx];
		endcase
	end

	// Body storage
	always_ff @(posedge clk) begin
		if (wr_en)
			body_buf[wr_idx] <= reply_bus.data;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_idx     <= '0;
			tx_idx     <= '0;
			busy       <= 1'b0;
			skip       <= 1'b0;
			reply_sent <= 1'b0;
			reply_lost <= 1'b0;
		end else begin
			reply_sent <= 1'b0;
			reply_lost <= 1'b0;

			// New or dropped reply restarts the buffer
			if (reply_bus.start || reply_bus.drop)
				wr_idx <= '0;
			else if (wr_en)
				wr_idx <= wr_idx + 3'd1;
			if (reply_bus.start)
				skip <= busy;

			// Word handshake
			if (busy && tx_ready) begin
				if (tx_last) begin
					busy       <= 1'b0;
					reply_sent <= 1'b1;
				end else begin
					tx_idx <= tx_idx + 4'd1;
				end
			end

			// Launch a complete body, or count it as lost
			if (reply_bus.commit) begin
				wr_idx <= '0;
				if (busy || skip) begin
					reply_lost <= 1'b1;
				end else if (body_full) begin
					busy   <= 1'b1;
					tx_idx <= '0;
					dst_q  <= reply_bus.dst_mac;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: design/arp_config_regs.sv
`timescale 1ns/10ps
`default_nettype none

module arp_config_regs import arp_pkg::*; #(
	parameter mac_addr_t  RESET_MAC = 48'h02_00_00_00_00_01,
	parameter ipv4_addr_t RESET_IP  = 32'hC0A8_0001
) (
	input  wire              clk,
	input  wire              rst,
	input  wire              psel,
	input  wire              penable,
	input  wire              pwrite,
	input  wire apb_addr_t   paddr,
	input  wire [31:0]       pwdata,
	output logic [31:0]      prdata,
	output logic             pready,
	output logic             pslverr,
	input  wire              reply_sent,
	input  wire              reply_lost,
	output mac_addr_t        our_mac,
	output ipv4_addr_t       our_ip
);

	logic        access;
	logic        addr_ok;
	logic        read_only;
	perf_count_t replies;
	perf_count_t lost;

	// Counters stick at all ones
	function automatic perf_count_t sat_inc(perf_count_t value, logic inc);
		return (inc && (value != '1)) ? value + 16'd1 : value;
	endfunction

	// Zero wait states, every access completes at once
	assign access  = psel && penable;
	assign pready  = 1'b1;
	assign pslverr = access && (!addr_ok || (pwrite && read_only));

	////////////////////////////////////////////////////////////
	// Address decode and read mux

	always_comb begin
		addr_ok   = 1'b1;
		read_only = 1'b0;
		prdata    = '0;
		case (paddr)
			REG_MAC_HI:  prdata = {16'h0000, our_mac[47:32]};
			REG_MAC_LO:  prdata = our_mac[31:0];
			REG_IP:      prdata = our_ip;
			REG_REPLIES: begin
				prdata    = {16'h0000, replies};
				read_only = 1'b1;
			end
			REG_LOST: begin
				prdata    = {16'h0000, lost};
				read_only = 1'b1;
			end
			default: addr_ok = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			our_mac <= RESET_MAC;
			our_ip  <= RESET_IP;
			replies <= '0;
			lost    <= '0;
		end else begin
			replies <= sat_inc(replies, reply_sent);
			lost    <= sat_inc(lost, reply_lost);
			// Rejected writes leave the registers alone
			if (access && pwrite && !pslverr) begin
				case (paddr)
					REG_MAC_HI: our_mac[47:32] <= pwdata[15:0];
					REG_MAC_LO: our_mac[31:0]  <= pwdata;
					REG_IP:     our_ip         <= pwdata;
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: design/arp_offload_top.sv
`timescale 1ns/10ps
`default_nettype none

module arp_offload_top import arp_pkg::*; #(
	parameter mac_addr_t  RESET_MAC = 48'h02_00_00_00_00_01,
	parameter ipv4_addr_t RESET_IP  = 32'hC0A8_0001
) (
	input  wire              clk,
	input  wire              rst,
	// Receive stream from the MAC
	input  wire eth_rx_bus_t rx_bus,
	// Transmit stream to the MAC
	input  wire              tx_ready,
	output logic             tx_valid,
	output eth_word_t        tx_data,
	output logic             tx_last,
	output byte_count_t      tx_bytes_valid,
	// APB configuration port
	input  wire              psel,
	input  wire              penable,
	input  wire              pwrite,
	input  wire apb_addr_t   paddr,
	input  wire [31:0]       pwdata,
	output logic [31:0]      prdata,
	output logic             pready,
	output logic             pslverr
);

	mac_addr_t      our_mac;
	ipv4_addr_t     our_ip;
	eth_rx_bus_t    l2_bus;
	logic           headers_valid;
	logic           ethertype_is_arp;
	eth_tx_l2_bus_t reply_bus;
	logic           reply_sent;
	logic           reply_lost;

	eth_rx_header_parser parser_i (
		.clk              (clk),
		.rst              (rst),
		.rx_bus           (rx_bus),
		.our_mac          (our_mac),
		.l2_bus           (l2_bus),
		.headers_valid    (headers_valid),
		.ethertype_is_arp (ethertype_is_arp)
	);

	// Request checks and reply body
	arp_responder responder_i (
		.clk              (clk),
		.rst              (rst),
		.l2_bus           (l2_bus),
		.headers_valid    (headers_valid),
		.ethertype_is_arp (ethertype_is_arp),
		.our_mac          (our_mac),
		.our_ip           (our_ip),
		.reply_bus        (reply_bus)
	);

	eth_tx_framer framer_i (
		.clk            (clk),
		.rst            (rst),
		.reply_bus      (reply_bus),
		.our_mac        (our_mac),
		.tx_ready       (tx_ready),
		.tx_valid       (tx_valid),
		.tx_data        (tx_data),
		.tx_last        (tx_last),
		.tx_bytes_valid (tx_bytes_valid),
		.reply_sent     (reply_sent),
		.reply_lost     (reply_lost)
	);

	// Addresses and counters
	arp_config_regs #(
		.RESET_MAC (RESET_MAC),
		.RESET_IP  (RESET_IP)
	) regs_i (
		.clk        (clk),
		.rst        (rst),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr),
		.reply_sent (reply_sent),
		.reply_lost (reply_lost),
		.our_mac    (our_mac),
		.our_ip     (our_ip)
	);

endmodule

`default_nettype wire

// File: tests/arp_offload_checker.sv
`timescale 1ns/10ps
`default_nettype none

module arp_offload_checker import arp_pkg::*; (
	input  wire            clk,
	input  wire            rst,
	input  wire            tx_valid,
	input  wire            tx_ready,
	input  wire eth_word_t tx_data,
	input  wire            penable,
	input  wire            pslverr,
	input  wire            headers_valid
);

	// Offered word must wait unchanged for the MAC
	property tx_data_held;
		@(posedge clk) disable iff (rst)
		(tx_valid && !tx_ready) |=> $stable(tx_data);
	endproperty

	assert property (tx_data_held)
		else $error("tx_data changed while tx_valid was waiting for tx_ready");

	// Error response belongs to the access phase only
	assert property (@(posedge clk) pslverr |-> penable)
		else $error("pslverr raised outside an APB access phase");

	// Parser quiet through reset
	assert property (@(posedge clk) (rst && $past(rst)) |-> !headers_valid)
		else $error("headers_valid high during reset");

endmodule

bind arp_offload_top arp_offload_checker checker_i (
	.clk           (clk),
	.rst           (rst),
	.tx_valid      (tx_valid),
	.tx_ready      (tx_ready),
	.tx_data       (tx_data),
	.penable       (penable),
	.pslverr       (pslverr),
	.headers_valid (headers_valid)
);

`default_nettype wire

// File: tests/arp_offload_monitor.sv
`timescale 1ns/10ps
`default_nettype none

module arp_offload_monitor import arp_pkg::*; (
	input  wire              clk,
	input  wire              rst,
	input  wire              tx_valid,
	input  wire              tx_ready,
	input  wire eth_word_t   tx_data,
	input  wire              tx_last,
	input  wire byte_count_t tx_bytes_valid
);

	// Expected transmit words, oldest first
	eth_word_t exp_data [$];
	logic      exp_last [$];
	int        error_count = 0;

	// Queue one expected word
	function automatic void push_word(eth_word_t data, logic last);
		exp_data.push_back(data);
		exp_last.push_back(last);
	endfunction

	function automatic int pending();
		return exp_data.size();
	endfunction

	// Value compare, hex on mismatch
	function automatic void compare_value(string name, logic [31:0] got, logic [31:0] exp);
		if (got !== exp) begin
			error_count++;
			$display("Error %s got %h expected %h", name, got, exp);
		end
	endfunction

	// Failure without a value to show
	function automatic void note_failure(string what);
		error_count++;
		$display("Failure: %s", what);
	endfunction

	////////////////////////////////////////////////////////////
	// Transmit port watch

	always @(posedge clk) begin
		eth_word_t want;
		logic      want_last;
		if (!rst && tx_valid && tx_ready) begin
			if (exp_data.size() == 0) begin
				error_count++;
				$display("Failure: word %h sent on the transmit port with no frame expected",
					tx_data);
			end else begin
				want      = exp_data.pop_front();
				want_last = exp_last.pop_front();
				compare_value("tx_data", tx_data, want);
				compare_value("tx_last", {31'd0, tx_last}, {31'd0, want_last});
				compare_value("tx_bytes_valid", {29'd0, tx_bytes_valid}, 32'd4);
			end
		end
	end

endmodule

`default_nettype wire

// File: tests/arp_offload_tb.sv
`timescale 1ns/10ps
`default_nettype none

module arp_offload_tb import arp_pkg::*; ();

	localparam mac_addr_t  RESET_MAC = 48'h02_AA_BB_CC_DD_EE;
	localparam ipv4_addr_t RESET_IP  = 32'hC0A8_0A0A;
	// Addresses written over APB before the frames
	localparam mac_addr_t  OUR_MAC   = 48'h02_11_22_33_44_55;
	localparam ipv4_addr_t OUR_IP    = 32'h0A00_0042;
	localparam mac_addr_t  PEER_MAC  = 48'h00_1B_21_3C_4D_5E;
	localparam ipv4_addr_t PEER_IP   = 32'h0A00_0007;
	localparam mac_addr_t  OTHER_MAC = 48'h00_0C_29_AB_CD_EF;
	localparam ipv4_addr_t OTHER_IP  = 32'h0A00_0099;
	localparam int         NUM       = 14;
	localparam int         LIMIT     = NUM * 64 + 400;
	// Longest drain of one reply before giving up on it
	localparam int         DRAIN_LIMIT = 64;
	localparam logic [3:0] NO_TRUNC  = 4'hF;

	// Entry kinds, plain or part of an overlap pair
	localparam logic [1:0] K_PLAIN   = 2'd0;
	localparam logic [1:0] K_HOLD    = 2'd1;
	localparam logic [1:0] K_OVERLAP = 2'd2;

	typedef struct packed {
		logic [1:0]  kind;
		mac_addr_t   sender_mac;
		ipv4_addr_t  sender_ip;
		ipv4_addr_t  target_ip;
		mac_addr_t   dst_mac;
		logic [15:0] ethertype;
		logic [15:0] htype;
		logic [15:0] opcode;
		// Body word that is cut short, NO_TRUNC for a full frame
		logic [3:0]  trunc;
		logic        abort;
	} frame_t;

	logic        clk = 1'b0;
	logic        rst = 1'b1;
	eth_rx_bus_t rx_bus = '0;
	logic        tx_ready = 1'b0;
	logic        tx_valid;
	eth_word_t   tx_data;
	logic        tx_last;
	byte_count_t tx_bytes_valid;
	logic        psel = 1'b0;
	logic        penable = 1'b0;
	logic        pwrite = 1'b0;
	apb_addr_t   paddr = '0;
	logic [31:0] pwdata = '0;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;

	integer      seed = 32'h9322;
	logic        ready_low = 1'b0;
	int          cycles = 0;
	frame_t      frame_table [NUM];

	arp_offload_top #(
		.RESET_MAC (RESET_MAC),
		.RESET_IP  (RESET_IP)
	) dut_i (
		.clk            (clk),
		.rst            (rst),
		.rx_bus         (rx_bus),
		.tx_ready       (tx_ready),
		.tx_valid       (tx_valid),
		.tx_data        (tx_data),
		.tx_last        (tx_last),
		.tx_bytes_valid (tx_bytes_valid),
		.psel           (psel),
		.penable        (penable),
		.pwrite         (pwrite),
		.paddr          (paddr),
		.pwdata         (pwdata),
		.prdata         (prdata),
		.pready         (pready),
		.pslverr        (pslverr)
	);

	arp_offload_monitor monitor_i (
		.clk            (clk),
		.rst            (rst),
		.tx_valid       (tx_valid),
		.tx_ready       (tx_ready),
		.tx_data        (tx_data),
		.tx_last        (tx_last),
		.tx_bytes_valid (tx_bytes_valid)
	);

	// 4 ns clock
	always #2 clk = ~clk;

	// Random back-pressure, or held low for an overlap pair
	always @(posedge clk) begin
		#1;
		tx_ready = ready_low ? 1'b0 : 1'($random(seed));
	end

	// Run limit from the table length
	always @(posedge clk) begin
		cycles++;
		if (cycles > LIMIT) begin
			$display("Timeout: run still going after %0d cycles", LIMIT);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// APB access, entered and left 1 ns after a rising edge

	task automatic write_reg(input apb_addr_t addr, input logic [31:0] data,
			output logic err);
		psel    = 1'b1;
		pwrite  = 1'b1;
		paddr   = addr;
		pwdata  = data;
		@(posedge clk);
		#1 penable = 1'b1;
		#2 err = pslverr;
		monitor_i.compare_value("pready", {31'd0, pready}, 32'd1);
		@(posedge clk);
		#1 psel = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic read_reg(input apb_addr_t addr, output logic [31:0] data,
			output logic err);
		psel   = 1'b1;
		pwrite = 1'b0;
		paddr  = addr;
		@(posedge clk);
		#1 penable = 1'b1;
		// Mid-cycle sample of the access phase
		#2 data = prdata;
		err = pslverr;
		monitor_i.compare_value("pready", {31'd0, pready}, 32'd1);
		@(posedge clk);
		#1 psel = 1'b0;
		penable = 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// Frames

	function automatic frame_t make_entry(logic [1:0] kind, mac_addr_t dst,
			logic [15:0] etype, logic [15:0] htype, logic [15:0] op, ipv4_addr_t tip,
			logic [3:0] trunc, logic abort);
		frame_t f;
		f.kind       = kind;
		f.sender_mac = PEER_MAC;
		f.sender_ip  = PEER_IP;
		f.target_ip  = tip;
		f.dst_mac    = dst;
		f.ethertype  = etype;
		f.htype      = htype;
		f.opcode     = op;
		f.trunc      = trunc;
		f.abort      = abort;
		return f;
	endfunction

	// Answer only for an intact ARP request to our IP at our MAC or broadcast
	function automatic logic reply_due(frame_t f);
		logic dst_hit;
		dst_hit = (f.dst_mac == OUR_MAC) || (f.dst_mac == BROADCAST_MAC);
		return (f.kind != K_OVERLAP) && dst_hit && (f.ethertype == 16'h0806) &&
			(f.htype == 16'h0001) && (f.opcode == 16'h0001) && (f.target_ip == OUR_IP) &&
			(f.trunc == NO_TRUNC) && !f.abort;
	endfunction

	// Expected 11-word reply frame
	task automatic expect_reply(frame_t f);
		monitor_i.push_word({16'h0000, f.sender_mac[47:32]}, 1'b0);
		monitor_i.push_word(f.sender_mac[31:0], 1'b0);
		monitor_i.push_word(OUR_MAC[47:16], 1'b0);
		monitor_i.push_word({OUR_MAC[15:0], 16'h0806}, 1'b0);
		monitor_i.push_word(32'h0001_0800, 1'b0);
		monitor_i.push_word(32'h0604_0002, 1'b0);
		monitor_i.push_word(OUR_MAC[47:16], 1'b0);
		monitor_i.push_word({OUR_MAC[15:0], OUR_IP[31:16]}, 1'b0);
		monitor_i.push_word({OUR_IP[15:0], f.sender_mac[47:32]}, 1'b0);
		monitor_i.push_word(f.sender_mac[31:0], 1'b0);
		monitor_i.push_word(f.sender_ip, 1'b1);
	endtask

	task automatic send_frame(frame_t f);
		eth_word_t words [11];
		int        n;
		words[0]  = {16'h0000, f.dst_mac[47:32]};
		words[1]  = f.dst_mac[31:0];
		words[2]  = f.sender_mac[47:16];
		words[3]  = {f.sender_mac[15:0], f.ethertype};
		// ARP body, target hardware address left at zero
		words[4]  = {f.htype, 16'h0800};
		words[5]  = {16'h0604, f.opcode};
		words[6]  = f.sender_mac[47:16];
		words[7]  = {f.sender_mac[15:0], f.sender_ip[31:16]};
		words[8]  = {f.sender_ip[15:0], 16'h0000};
		words[9]  = 32'h0000_0000;
		words[10] = f.target_ip;
		n = (f.trunc == NO_TRUNC) ? 11 : 5 + int'(f.trunc);
		for (int i = 0; i < n; i++) begin
			rx_bus             = '0;
			rx_bus.start       = (i == 0);
			rx_bus.data_valid  = 1'b1;
			rx_bus.data        = words[i];
			rx_bus.bytes_valid = (f.trunc != NO_TRUNC && i == n - 1) ? 3'd2 : 3'd4;
			@(posedge clk);
			#1;
		end
		// End of frame on a cycle of its own
		rx_bus = '0;
		if (f.abort)
			rx_bus.drop = 1'b1;
		else
			rx_bus.commit = 1'b1;
		@(posedge clk);
		#1 rx_bus = '0;
	endtask

	// Let the pipeline settle, then drain any reply
	task automatic wait_idle();
		int waited;
		waited = 0;
		repeat (4) @(posedge clk);
		#1;
		// Words still queued after the drain show up in the final check
		while ((monitor_i.pending() != 0) && (waited < DRAIN_LIMIT)) begin
			@(posedge clk);
			#1;
			waited++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		logic [31:0] val;
		logic        err;
		int          replies;
		int          lost;
		frame_t      f;
		replies = 0;
		lost    = 0;

		frame_table[0]  = make_entry(K_PLAIN, BROADCAST_MAC, 16'h0806, 16'h0001, 16'h0001,
			OUR_IP, NO_TRUNC, 1'b0);
		frame_table[1]  = make_entry(K_PLAIN, OUR_MAC, 16'h0806, 16'h0001, 16'h0001,
			OUR_IP, NO_TRUNC, 1'b0);
		// IPv4 frame
		frame_table[2]  = make_entry(K_PLAIN, BROADCAST_MAC, 16'h0800, 16'h0001, 16'h0001,
			OUR_IP, NO_TRUNC, 1'b0);
		frame_table[3]  = make_entry(K_PLAIN, OTHER_MAC, 16'h0806, 16'h0001, 16'h0001,
			OUR_IP, NO_TRUNC, 1'b0);
		frame_table[4]  = make_entry(K_PLAIN, BROADCAST_MAC, 16'h0806, 16'h0001, 16'h0001,
			OTHER_IP, NO_TRUNC, 1'b0);
		// ARP reply, bad HTYPE, unknown opcode
		frame_table[5]  = make_entry(K_PLAIN, OUR_MAC, 16'h0806, 16'h0001, 16'h0002,
			OUR_IP, NO_TRUNC, 1'b0);
		frame_table[6]  = make_entry(K_PLAIN, BROADCAST_MAC, 16'h0806, 16'h0006, 16'h0001,
			OUR_IP, NO_TRUNC, 1'b0);
		frame_table[7]  = make_entry(K_PLAIN, BROADCAST_MAC, 16'h0806, 16'h0001, 16'h0003,
			OUR_IP, NO_TRUNC, 1'b0);
		// Short word at body word 4, then an abort
		frame_table[8]  = make_entry(K_PLAIN, BROADCAST_MAC, 16'h0806, 16'h0001, 16'h0001,
			OUR_IP, 4'd4, 1'b0);
		frame_table[9]  = make_entry(K_PLAIN, BROADCAST_MAC, 16'h0806, 16'h0001, 16'h0001,
			OUR_IP, NO_TRUNC, 1'b1);
		frame_table[10] = make_entry(K_PLAIN, BROADCAST_MAC, 16'h0806, 16'h0001, 16'h0001,
			OUR_IP, NO_TRUNC, 1'b0);
		// Back-to-back pair with the MAC stalled
		frame_table[11] = make_entry(K_HOLD, OUR_MAC, 16'h0806, 16'h0001, 16'h0001,
			OUR_IP, NO_TRUNC, 1'b0);
		frame_table[12] = make_entry(K_OVERLAP, BROADCAST_MAC, 16'h0806, 16'h0001, 16'h0001,
			OUR_IP, NO_TRUNC, 1'b0);
		frame_table[13] = make_entry(K_PLAIN, OUR_MAC, 16'h0806, 16'h0001, 16'h0001,
			OUR_IP, NO_TRUNC, 1'b0);

		repeat (8) @(posedge clk);
		#1 rst = 1'b0;

		// Reset values
		read_reg(REG_MAC_HI, val, err);
		monitor_i.compare_value("REG_MAC_HI", val, {16'h0000, RESET_MAC[47:32]});
		read_reg(REG_MAC_LO, val, err);
		monitor_i.compare_value("REG_MAC_LO", val, RESET_MAC[31:0]);
		read_reg(REG_IP, val, err);
		monitor_i.compare_value("REG_IP", val, RESET_IP);

		// Our addresses, read back
		write_reg(REG_MAC_HI, {16'h0000, OUR_MAC[47:32]}, err);
		write_reg(REG_MAC_LO, OUR_MAC[31:0], err);
		write_reg(REG_IP, OUR_IP, err);
		read_reg(REG_MAC_HI, val, err);
		monitor_i.compare_value("REG_MAC_HI", val, {16'h0000, OUR_MAC[47:32]});
		read_reg(REG_MAC_LO, val, err);
		monitor_i.compare_value("REG_MAC_LO", val, OUR_MAC[31:0]);
		read_reg(REG_IP, val, err);
		monitor_i.compare_value("REG_IP", val, OUR_IP);

		// Error responses
		read_reg(8'h14, val, err);
		monitor_i.compare_value("pslverr", {31'd0, err}, 32'd1);
		write_reg(REG_REPLIES, 32'h0000_0005, err);
		monitor_i.compare_value("pslverr", {31'd0, err}, 32'd1);

		for (int i = 0; i < NUM; i++) begin
			f = frame_table[i];
			if (f.kind == K_HOLD)
				ready_low = 1'b1;
			if (reply_due(f)) begin
				expect_reply(f);
				replies++;
			end
			if (f.kind == K_OVERLAP)
				lost++;
			send_frame(f);
			if (f.kind != K_HOLD) begin
				ready_low = 1'b0;
				wait_idle();
			end
		end

		if (monitor_i.pending() != 0)
			monitor_i.note_failure("expected reply words were never sent");

		read_reg(REG_REPLIES, val, err);
		monitor_i.compare_value("REG_REPLIES", val, replies);
		read_reg(REG_LOST, val, err);
		monitor_i.compare_value("REG_LOST", val, lost);

		$display("Run complete with %0d errors", monitor_i.error_count);
		if (monitor_i.error_count == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
design/arp_pkg.sv
design/eth_rx_header_parser.sv
design/arp_responder.sv
design/eth_tx_framer.sv
design/arp_config_regs.sv
design/arp_offload_top.sv
tests/arp_offload_checker.sv
tests/arp_offload_monitor.sv
tests/arp_offload_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile with Verilator and run the ARP offload testbench
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module arp_offload_tb -f build.f -o arp_offload_sim

./obj_dir/arp_offload_sim | tee sim.log

if grep -q "^NO ERRORS$" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
